/* alu.sv */
`timescale 1ns/1ps
`default_nettype none

module alu (
	input  wire cpu_pkg::alu_op_e op,
	input  wire logic [31:0]      a,
	input  wire logic [31:0]      b,
	output logic [31:0]           y
);

	logic [4:0] shamt;
	logic [63:0] rot;

	assign shamt = b[4:0];
	// rotate by shifting a doubled word
	assign rot = {a, a} >> shamt;

	always_comb begin
		case (op)
			cpu_pkg::alu_add:  y = a + b;
			cpu_pkg::alu_sub:  y = a - b;
			cpu_pkg::alu_and:  y = a & b;
			cpu_pkg::alu_or:   y = a | b;
			cpu_pkg::alu_xor:  y = a ^ b;
			cpu_pkg::alu_srl:  y = a >> shamt;
			cpu_pkg::alu_sll:  y = a << shamt;
			cpu_pkg::alu_rotr: y = rot[31:0];
			default:           y = b;
		endcase
	end

	always_comb begin
		if (!$isunknown({op, a, b})) begin
			assert final (!$isunknown(y));
		end
	end

endmodule

`default_nettype wire

/* controller.sv */
`timescale 1ns/1ps
`default_nettype none

module controller (
	input  wire logic            clock,
	input  wire logic            reset,
	input  wire logic            running,
	input  wire logic [31:0]     instr,
	output logic                 halted,
	output cpu_pkg::ctrl_t       ctrl
);

	cpu_pkg::ctrl_state_e state, next_state;
	cpu_pkg::opcode_e opcode;
	cpu_pkg::base_sub_e sub_base;
	cpu_pkg::ls_sub_e sub_ls;
	logic dec_write, dec_load, dec_store, dec_halt;

	assign opcode = cpu_pkg::opcode_e'(instr[cpu_pkg::opcode_lsb +: 6]);
	assign sub_base = cpu_pkg::base_sub_e'(instr[cpu_pkg::sub_base_lsb +: 5]);
	assign sub_ls = cpu_pkg::ls_sub_e'(instr[cpu_pkg::sub_ls_lsb +: 8]);

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= cpu_pkg::s_fetch;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		case (state)
			// wait here until the host starts the core
			cpu_pkg::s_fetch:     next_state = running ? cpu_pkg::s_latch : cpu_pkg::s_fetch;
			cpu_pkg::s_latch:     next_state = cpu_pkg::s_execute;
			cpu_pkg::s_execute:   next_state = cpu_pkg::s_writeback;
			default:              next_state = cpu_pkg::s_fetch;
		endcase
	end

	always_comb begin
		ctrl.alu_op = cpu_pkg::alu_pass_b;
		ctrl.operand_sel = cpu_pkg::opnd_reg;
		ctrl.result_sel = cpu_pkg::res_alu;
		dec_write = 1'b0;
		dec_load = 1'b0;
		dec_store = 1'b0;
		dec_halt = 1'b0;
		case (opcode)
			cpu_pkg::op_type_base: begin
				dec_write = 1'b1;
				case (sub_base)
					cpu_pkg::base_add: ctrl.alu_op = cpu_pkg::alu_add;
					cpu_pkg::base_sub: ctrl.alu_op = cpu_pkg::alu_sub;
					cpu_pkg::base_and: ctrl.alu_op = cpu_pkg::alu_and;
					cpu_pkg::base_or:  ctrl.alu_op = cpu_pkg::alu_or;
					cpu_pkg::base_xor: ctrl.alu_op = cpu_pkg::alu_xor;
					cpu_pkg::base_srli: begin
						ctrl.alu_op = cpu_pkg::alu_srl;
						ctrl.operand_sel = cpu_pkg::opnd_imm5;
					end
					cpu_pkg::base_slli: begin
						ctrl.alu_op = cpu_pkg::alu_sll;
						ctrl.operand_sel = cpu_pkg::opnd_imm5;
					end
					cpu_pkg::base_rotri: begin
						ctrl.alu_op = cpu_pkg::alu_rotr;
						ctrl.operand_sel = cpu_pkg::opnd_imm5;
					end
					default: dec_write = 1'b0;
				endcase
			end
			cpu_pkg::op_addi, cpu_pkg::op_ori, cpu_pkg::op_xori: begin
				dec_write = 1'b1;
				ctrl.operand_sel = cpu_pkg::opnd_imm15;
				if (opcode == cpu_pkg::op_addi) begin
					ctrl.alu_op = cpu_pkg::alu_add;
				end else if (opcode == cpu_pkg::op_ori) begin
					ctrl.alu_op = cpu_pkg::alu_or;
				end else begin
					ctrl.alu_op = cpu_pkg::alu_xor;
				end
			end
			cpu_pkg::op_movi: begin
				dec_write = 1'b1;
				ctrl.result_sel = cpu_pkg::res_imm20;
			end
			cpu_pkg::op_lwi, cpu_pkg::op_swi: begin
				ctrl.alu_op = cpu_pkg::alu_add;
				ctrl.operand_sel = cpu_pkg::opnd_imm15;
				ctrl.result_sel = cpu_pkg::res_mem;
				dec_write = (opcode == cpu_pkg::op_lwi);
				dec_load = (opcode == cpu_pkg::op_lwi);
				dec_store = (opcode == cpu_pkg::op_swi);
			end
			cpu_pkg::op_type_ls: begin
				ctrl.alu_op = cpu_pkg::alu_add;
				ctrl.operand_sel = cpu_pkg::opnd_reg_offset;
				ctrl.result_sel = cpu_pkg::res_mem;
				dec_write = (sub_ls == cpu_pkg::ls_lw);
				dec_load = (sub_ls == cpu_pkg::ls_lw);
				dec_store = (sub_ls == cpu_pkg::ls_sw);
			end
			cpu_pkg::op_halt: dec_halt = 1'b1;
			default: ;
		endcase
	end

	// strobes follow the state
	assign ctrl.fetch = (state == cpu_pkg::s_fetch) && running;
	assign ctrl.pc_enable = (state == cpu_pkg::s_latch);
	assign ctrl.mem_read = dec_load && (state == cpu_pkg::s_execute);
	assign ctrl.mem_write = dec_store && (state == cpu_pkg::s_writeback);
	assign ctrl.reg_write = dec_write && (state == cpu_pkg::s_writeback);
	assign halted = dec_halt && (state == cpu_pkg::s_execute);

	assert property (@(posedge clock) disable iff (reset) !(ctrl.mem_read && ctrl.mem_write));
	// a register write comes straight after the execute cycle
	assert property (@(posedge clock) disable iff (reset)
		ctrl.reg_write |-> $past(state) == cpu_pkg::s_execute);

endmodule

`default_nettype wire

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// instruction field positions
	localparam int opcode_lsb = 25;
	localparam int rt_lsb = 20;
	localparam int ra_lsb = 15;
	localparam int rb_lsb = 10;
	localparam int imm5_lsb = 10;
	localparam int sv_lsb = 8;
	localparam int imm15_lsb = 0;
	localparam int imm20_lsb = 0;
	localparam int sub_base_lsb = 0;
	localparam int sub_ls_lsb = 0;

	typedef enum logic [5:0] {
		op_type_base = 6'b100000,
		op_addi      = 6'b101000,
		op_ori       = 6'b101100,
		op_xori      = 6'b101011,
		op_movi      = 6'b100010,
		op_lwi       = 6'b000010,
		op_swi       = 6'b001010,
		op_type_ls   = 6'b011100,
		op_halt      = 6'b111111
	} opcode_e;

	typedef enum logic [4:0] {
		base_add   = 5'b00000,
		base_sub   = 5'b00001,
		base_and   = 5'b00010,
		base_xor   = 5'b00011,
		base_or    = 5'b00100,
		base_slli  = 5'b01000,
		base_srli  = 5'b01001,
		base_rotri = 5'b01011
	} base_sub_e;

	typedef enum logic [7:0] {
		ls_lw = 8'b00000010,
		ls_sw = 8'b00001010
	} ls_sub_e;

	typedef enum logic [1:0] {s_fetch, s_latch, s_execute, s_writeback} ctrl_state_e;

	typedef enum logic [3:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_xor,
		alu_srl, alu_sll, alu_rotr, alu_pass_b
	} alu_op_e;

	// second alu operand
	typedef enum logic [1:0] {opnd_reg, opnd_imm5, opnd_imm15, opnd_reg_offset} operand_sel_e;

	typedef enum logic [1:0] {res_alu, res_imm20, res_mem} result_sel_e;

	typedef struct packed {
		alu_op_e      alu_op;
		operand_sel_e operand_sel;
		result_sel_e  result_sel;
		logic         reg_write;
		logic         mem_read;
		logic         mem_write;
		logic         fetch;
		logic         pc_enable;
	} ctrl_t;

	typedef struct packed {
		logic        psel;
		logic        penable;
		logic        pwrite;
		logic [11:0] paddr;
		logic [31:0] pwdata;
	} apb_req_t;

endpackage

`default_nettype wire

/* cpu_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cpu_top #(
	parameter int IMEM_WORDS = 64,
	parameter int DMEM_WORDS = 64
) (
	input  wire logic              clock,
	input  wire logic              reset,
	input  wire cpu_pkg::apb_req_t apb,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr
);

	cpu_pkg::ctrl_t ctrl;
	logic [31:0] pc, instr;
	logic running, halted, pc_clear;
	logic [$clog2(DMEM_WORDS)-1:0] dbg_addr;
	logic [31:0] dbg_rdata, mem_rdata;
	logic [31:0] ra_data, rb_data, rt_data;
	logic [31:0] operand_b, alu_y, result;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_clear) begin
			pc <= '0;
		end else if (ctrl.pc_enable) begin
			pc <= pc + 32'd1;
		end
	end

	always_comb begin
		case (ctrl.operand_sel)
			cpu_pkg::opnd_imm5:
				operand_b = {27'b0, instr[cpu_pkg::imm5_lsb +: 5]};
			cpu_pkg::opnd_imm15:
				operand_b = {{17{instr[cpu_pkg::imm15_lsb + 14]}}, instr[cpu_pkg::imm15_lsb +: 15]};
			// rb scaled by the sv field
			cpu_pkg::opnd_reg_offset:
				operand_b = rb_data << instr[cpu_pkg::sv_lsb +: 2];
			default:
				operand_b = rb_data;
		endcase
	end

	always_comb begin
		case (ctrl.result_sel)
			cpu_pkg::res_imm20:
				result = {{12{instr[cpu_pkg::imm20_lsb + 19]}}, instr[cpu_pkg::imm20_lsb +: 20]};
			cpu_pkg::res_mem: result = mem_rdata;
			default:          result = alu_y;
		endcase
	end

	debug_apb #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_debug (
		.clock(clock), .reset(reset), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr), .fetch(ctrl.fetch), .pc(pc), .instr(instr), .halted(halted),
		.running(running), .pc_clear(pc_clear), .dmem_addr(dbg_addr),
		.dmem_rdata(dbg_rdata)
	);

	controller u_ctrl (
		.clock(clock), .reset(reset), .running(running), .instr(instr),
		.halted(halted), .ctrl(ctrl)
	);

	reg_file u_regs (
		.clock(clock), .reset(reset),
		.ra_addr(instr[cpu_pkg::ra_lsb +: 5]), .rb_addr(instr[cpu_pkg::rb_lsb +: 5]),
		.rt_addr(instr[cpu_pkg::rt_lsb +: 5]), .write(ctrl.reg_write), .wdata(result),
		.ra_data(ra_data), .rb_data(rb_data), .rt_data(rt_data)
	);

	alu u_alu (.op(ctrl.alu_op), .a(ra_data), .b(operand_b), .y(alu_y));

	data_memory #(.DMEM_WORDS(DMEM_WORDS)) u_dmem (
		.clock(clock), .read(ctrl.mem_read), .write(ctrl.mem_write), .addr(alu_y),
		.wdata(rt_data), .rdata(mem_rdata), .dbg_addr(dbg_addr), .dbg_rdata(dbg_rdata)
	);

endmodule

`default_nettype wire

/* cpu_vectors.txt */
# name, mode (0 plain, 1 random register numbers, 2 imem write while running), word count
# then program words in hex, pair count, and data word index (dec) with expected word (hex)
alu_rr 0 14
44000000 44112345 442F0F0F 40308800 14300000 40308801 14300001
40308802 14300002 40308804 14300003 40308803 14300004 7E000000
5 0 00003254 1 00021436 2 00010305 3 FFFF2F4F 4 FFFE2C4A
shift_imm 0 11
44000000 441F1234 40309009 14300008 4030A008 14300009
4030B00B 1430000A 4030FC09 1430000B 7E000000
4 8 0FFFF123 9 FF123400 10 234FFFF1 11 00000001
imm_ext 0 13
44000000 44100100 5030FFFB 1430000C 58308055 1430000D
5630FFFF 1430000E 44380000 1430000F 4437FFFF 14300010 7E000000
5 12 000000FB 13 00000155 14 FFFFFEFF 15 FFF80000 16 0007FFFF
mem_round 0 12
44000000 441ABCDE 14100014 04200014 14200015 44500016
44400002 50608001 3862910A 38729102 1470001B 7E000000
4 20 FFFABCDE 21 FFFABCDE 26 FFFABCDF 27 FFFABCDF
halt_stop 0 6
44000000 44100055 1410001E 1400001F 7E000000 1410001F
2 30 00000055 31 00000000
imem_guard 2 6
44000000 44100777 44200111 40308800 14300028 7E000000
1 40 00000888
rand_regs 1 12
40421003 40108403 40210803 50109234 50217F00 40308800
14320030 40308803 14320031 40310401 14320032 7E000000
3 48 00001134 49 FFFFED34 50 FFFFECCC

/* data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory #(
	parameter int DMEM_WORDS = 64
) (
	input  wire logic                          clock,
	input  wire logic                          read,
	input  wire logic                          write,
	input  wire logic [31:0]                   addr,
	input  wire logic [31:0]                   wdata,
	output logic [31:0]                        rdata,
	input  wire logic [$clog2(DMEM_WORDS)-1:0] dbg_addr,
	output logic [31:0]                        dbg_rdata
);

	logic [31:0] mem [DMEM_WORDS];
	logic [$clog2(DMEM_WORDS)-1:0] index;

	assign index = addr[$clog2(DMEM_WORDS)-1:0];

	always_ff @(posedge clock) begin
		if (write) begin
			mem[index] <= wdata;
		end
		if (read) begin
			rdata <= mem[index];
		end
	end

	// host read-back path
	assign dbg_rdata = mem[dbg_addr];

	assert property (@(posedge clock) (read || write) |-> addr < DMEM_WORDS);

endmodule

`default_nettype wire

/* debug_apb.sv */
`timescale 1ns/1ps
`default_nettype none

module debug_apb #(
	parameter int IMEM_WORDS = 64,
	parameter int DMEM_WORDS = 64
) (
	input  wire logic                   clock,
	input  wire logic                   reset,
	input  wire cpu_pkg::apb_req_t      apb,
	output logic [31:0]                 prdata,
	output logic                        pready,
	output logic                        pslverr,
	input  wire logic                   fetch,
	input  wire logic [31:0]            pc,
	output logic [31:0]                 instr,
	input  wire logic                   halted,
	output logic                        running,
	output logic                        pc_clear,
	output logic [$clog2(DMEM_WORDS)-1:0] dmem_addr,
	input  wire logic [31:0]            dmem_rdata
);

	logic [31:0] imem [IMEM_WORDS];
	logic [$clog2(IMEM_WORDS)-1:0] imem_index;
	logic access, imem_hit, ctrl_hit, dmem_hit;
	logic imem_we, ctrl_we;

	assign access = apb.psel && apb.penable;
	assign imem_index = apb.paddr[2 +: $clog2(IMEM_WORDS)];
	assign dmem_addr = apb.paddr[2 +: $clog2(DMEM_WORDS)];

	// windows: 0x000 imem, 0x100 control, 0x200 dmem
	assign imem_hit = (apb.paddr[11:8] == 4'h0) && (apb.paddr[7:2] < IMEM_WORDS);
	assign ctrl_hit = (apb.paddr == 12'h100);
	assign dmem_hit = (apb.paddr[11:8] == 4'h2) && (apb.paddr[7:2] < DMEM_WORDS);

	assign imem_we = access && apb.pwrite && imem_hit && !running;
	assign ctrl_we = access && apb.pwrite && ctrl_hit;
	assign pc_clear = ctrl_we && apb.pwdata[0];

	assign pready = 1'b1;
	assign pslverr = access && ((imem_hit && (!apb.pwrite || running))
		|| (dmem_hit && apb.pwrite)
		|| !(imem_hit || ctrl_hit || dmem_hit));

	always_comb begin
		if (ctrl_hit) begin
			prdata = {31'b0, running};
		end else if (dmem_hit) begin
			prdata = dmem_rdata;
		end else begin
			prdata = '0;
		end
	end

	always_ff @(posedge clock) begin
		if (imem_we) begin
			imem[imem_index] <= apb.pwdata;
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instr <= '0;
			running <= 1'b0;
		end else begin
			if (fetch) begin
				instr <= imem[pc[$clog2(IMEM_WORDS)-1:0]];
			end
			// the host write takes priority over a halt
			if (ctrl_we) begin
				running <= apb.pwdata[0];
			end else if (halted) begin
				running <= 1'b0;
			end
		end
	end

	assert property (@(posedge clock) disable iff (reset) $rose(apb.penable) |-> apb.psel);

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
	input  wire logic        clock,
	input  wire logic        reset,
	input  wire logic [4:0]  ra_addr,
	input  wire logic [4:0]  rb_addr,
	input  wire logic [4:0]  rt_addr,
	input  wire logic        write,
	input  wire logic [31:0] wdata,
	output logic [31:0]      ra_data,
	output logic [31:0]      rb_data,
	output logic [31:0]      rt_data
);

	logic [31:0] regs [32];

	// r0 is an ordinary register here
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (write) begin
			regs[rt_addr] <= wdata;
		end
	end

	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];
	assign rt_data = regs[rt_addr];

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_cpu -f tb.f -o tb_cpu
./obj_dir/tb_cpu | tee sim.log
if grep -qx "Done: no errors" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb.f */
cpu_pkg.sv
controller.sv
alu.sv
reg_file.sv
data_memory.sv
debug_apb.sv
cpu_top.sv
tb_cpu.sv

/* tb_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

	logic clock;
	logic reset;
	cpu_pkg::apb_req_t apb;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;

	string names[$];
	int modes[$];
	int word_base[$];
	int word_count[$];
	int pair_base[$];
	int pair_count[$];
	logic [31:0] words[$];
	int addrs[$];
	logic [31:0] expected_words[$];
	logic [4:0] reg_map[32];
	int errors = 0;
	int checks = 0;
	int cycles = 0;
	int cycle_limit = 20;

	cpu_top #(.IMEM_WORDS(64), .DMEM_WORDS(64)) dut0 (
		.clock(clock), .reset(reset), .apb(apb), .prdata(prdata), .pready(pready),
		.pslverr(pslverr)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	// watchdog whose limit grows as tests are read
	initial begin
		while (cycles <= cycle_limit) begin
			@(posedge clock);
			cycles++;
		end
		$display("timeout: the tests did not finish within %0d cycles", cycle_limit);
		$display("checks: %0d, errors: %0d", checks, errors);
		$display("Done: errors found");
		$finish;
	end

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("[ERROR] %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	task automatic load_vectors();
		int fd;
		int code;
		int mode;
		int count;
		int addr;
		string tok;
		string line;
		logic [31:0] value;
		fd = $fopen("cpu_vectors.txt", "r");
		if (fd == 0) begin
			errors++;
			$display("could not open cpu_vectors.txt, no tests were run");
		end else begin
			while ($fscanf(fd, "%s", tok) == 1) begin
				if (tok.getc(0) == "#") begin
					code = $fgets(line, fd);
				end else begin
					code = $fscanf(fd, "%d %d", mode, count);
					names.push_back(tok);
					modes.push_back(mode);
					word_base.push_back(words.size());
					word_count.push_back(count);
					for (int i = 0; i < count; i++) begin
						code = $fscanf(fd, "%h", value);
						words.push_back(value);
					end
					cycle_limit += 8 * count + 50;
					code = $fscanf(fd, "%d", count);
					pair_base.push_back(addrs.size());
					pair_count.push_back(count);
					for (int i = 0; i < count; i++) begin
						code = $fscanf(fd, "%d %h", addr, value);
						addrs.push_back(addr);
						expected_words.push_back(value);
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apb_transfer(input logic write, input logic [11:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err);
		@(negedge clock);
		apb.psel = 1'b1;
		apb.penable = 1'b0;
		apb.pwrite = write;
		apb.paddr = addr;
		apb.pwdata = data;
		@(negedge clock);
		apb.penable = 1'b1;
		#1;
		// the access ends at the next rising edge
		check_value("apb access pready", 32'd1, {31'b0, pready});
		rdata = prdata;
		err = pslverr;
		@(negedge clock);
		apb.psel = 1'b0;
		apb.penable = 1'b0;
	endtask

	task automatic shuffle_regs();
		int j;
		logic [4:0] tmp;
		for (int i = 0; i < 32; i++) begin
			reg_map[i] = 5'(i);
		end
		for (int i = 31; i > 0; i--) begin
			j = int'($urandom % (i + 1));
			tmp = reg_map[i];
			reg_map[i] = reg_map[j];
			reg_map[j] = tmp;
		end
	endtask

	// a register permutation keeps the program's results
	function automatic logic [31:0] remap_regs(input logic [31:0] w);
		logic [31:0] r;
		r = w;
		r[cpu_pkg::rt_lsb +: 5] = reg_map[w[cpu_pkg::rt_lsb +: 5]];
		r[cpu_pkg::ra_lsb +: 5] = reg_map[w[cpu_pkg::ra_lsb +: 5]];
		if (w[cpu_pkg::opcode_lsb +: 6] == cpu_pkg::op_type_base) begin
			r[cpu_pkg::rb_lsb +: 5] = reg_map[w[cpu_pkg::rb_lsb +: 5]];
		end
		return r;
	endfunction

	task automatic run_test(input int t);
		logic [31:0] word;
		logic [31:0] rdata;
		logic err;
		int a;
		if (modes[t] == 1) begin
			shuffle_regs();
		end
		for (int i = 0; i < word_count[t]; i++) begin
			word = words[word_base[t] + i];
			if (modes[t] == 1) begin
				word = remap_regs(word);
			end
			apb_transfer(1'b1, 12'(4 * i), word, rdata, err);
			check_value($sformatf("%s imem[%0d] pslverr", names[t], i), 32'd0, {31'b0, err});
		end
		apb_transfer(1'b1, 12'h100, 32'd1, rdata, err);
		check_value($sformatf("%s start pslverr", names[t]), 32'd0, {31'b0, err});
		if (modes[t] == 2) begin
			// try to turn the last store into a halt
			word = {1'b0, cpu_pkg::op_halt, 25'b0};
			apb_transfer(1'b1, 12'(4 * (word_count[t] - 2)), word, rdata, err);
			check_value($sformatf("%s busy write pslverr", names[t]), 32'd1, {31'b0, err});
		end
		rdata = 32'd1;
		while (rdata[0] == 1'b1) begin
			apb_transfer(1'b0, 12'h100, 32'd0, rdata, err);
		end
		for (int p = 0; p < pair_count[t]; p++) begin
			a = addrs[pair_base[t] + p];
			apb_transfer(1'b0, 12'h200 + 12'(4 * a), 32'd0, rdata, err);
			check_value($sformatf("%s dmem[%0d]", names[t], a),
				expected_words[pair_base[t] + p], rdata);
		end
	endtask

	initial begin
		reset = 1'b1;
		apb = '0;
		void'($urandom(32'h24fa));
		load_vectors();
		repeat (10) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		for (int t = 0; t < names.size(); t++) begin
			run_test(t);
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire
